// File: scratch_ram_pkg.sv
`default_nettype none

package scratch_ram_pkg;

    // ------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------
    localparam int ADDR_W     = 8;
    localparam int ROW_ADDR_W = ADDR_W - 1;
    localparam int TILE_DEPTH = 1 << ROW_ADDR_W;
    localparam int NUM_ROWS   = 2;

    // One data lane, also the payload of a data tile
    typedef logic [7:0] byte_t;

    // ------------------------------------------------------------
    // SECDED helpers
    // ------------------------------------------------------------

    // Hamming bits r with 2**r >= data + r + 1, plus overall parity
    function automatic int ecc_check_width(input int data_w);
        int r;
        r = 1;
        for (int i = 1; i < 8; i++)
        begin
            if ((1 << r) < data_w + r + 1)
                r++;
        end
        return r + 1;
    endfunction

    // Codeword position of data bit idx; powers of two hold check bits
    function automatic int ecc_data_pos(input int idx);
        int pos;
        int seen;
        pos  = 0;
        seen = 0;
        for (int p = 3; p < 64; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                if (seen == idx)
                    pos = p;
                seen++;
            end
        end
        return pos;
    endfunction

endpackage

`default_nettype wire

// File: array_if.sv
`default_nettype none

interface array_if #(
    parameter int DATA_WIDTH = 32
);
    localparam int CHECK_W = scratch_ram_pkg::ecc_check_width(DATA_WIDTH);

    // Write side
    logic [scratch_ram_pkg::NUM_ROWS-1:0]   row_wen;
    logic [scratch_ram_pkg::ROW_ADDR_W-1:0] tile_addr;
    logic                                   row_sel_q;
    logic [DATA_WIDTH-1:0]                  wr_data;
    logic [CHECK_W-1:0]                     wr_check;

    // Read side, codeword as stored
    logic [DATA_WIDTH-1:0]                  rd_data;
    logic [CHECK_W-1:0]                     rd_check;

    modport ctrl  (output row_wen, tile_addr, row_sel_q);
    modport enc   (output wr_data, wr_check);
    modport array (input row_wen, tile_addr, row_sel_q, wr_data, wr_check,
                   output rd_data, rd_check);
    modport dec   (input rd_data, rd_check);

endinterface

`default_nettype wire

// File: ram_tile.sv
`default_nettype none

// 128-deep tile; read data is registered, old contents on a same-address write
module ram_tile #(
    parameter type payload_t = scratch_ram_pkg::byte_t
) (
    input  logic                                   CLK,
    input  logic                                   wen,
    input  logic [scratch_ram_pkg::ROW_ADDR_W-1:0] addr,
    input  payload_t                               wd,
    output payload_t                               rd
);

    payload_t mem [scratch_ram_pkg::TILE_DEPTH];

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (wen)
            mem[addr] <= wd;
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        rd <= mem[addr];
    end

endmodule

`default_nettype wire

// File: ram_array.sv
`default_nettype none

module ram_array #(
    parameter int DATA_WIDTH = 32
) (
    input  logic  CLK,
    array_if.array mem
);

    localparam int CHECK_W   = scratch_ram_pkg::ecc_check_width(DATA_WIDTH);
    localparam int NUM_LANES = DATA_WIDTH / 8;

    typedef logic [CHECK_W-1:0] check_t;

    // Per-row read data before the row mux
    logic [DATA_WIDTH-1:0] row_data  [scratch_ram_pkg::NUM_ROWS];
    check_t                row_check [scratch_ram_pkg::NUM_ROWS];

    // ------------------------------------------------------------
    // Tile grid: one byte tile per lane plus one check tile per row
    // ------------------------------------------------------------
    for (genvar r = 0; r < scratch_ram_pkg::NUM_ROWS; r++)
    begin : g_row
        for (genvar c = 0; c < NUM_LANES; c++)
        begin : g_lane
            ram_tile #(
                .payload_t (scratch_ram_pkg::byte_t)
            ) u_data_tile (
                .CLK  (CLK),
                .wen  (mem.row_wen[r]),
                .addr (mem.tile_addr),
                .wd   (mem.wr_data[c*8 +: 8]),
                .rd   (row_data[r][c*8 +: 8])
            );
        end

        ram_tile #(
            .payload_t (check_t)
        ) u_check_tile (
            .CLK  (CLK),
            .wen  (mem.row_wen[r]),
            .addr (mem.tile_addr),
            .wd   (mem.wr_check),
            .rd   (row_check[r])
        );
    end

    // Row mux, steered by the row select of the previous cycle
    assign mem.rd_data  = row_data[mem.row_sel_q];
    assign mem.rd_check = row_check[mem.row_sel_q];

endmodule

`default_nettype wire

// File: ram_bank_ctrl.sv
`default_nettype none

module ram_bank_ctrl (
    input  logic                               CLK,
    input  logic                               rst,
    input  logic                               wen,
    input  logic [scratch_ram_pkg::ADDR_W-1:0] addr,
    array_if.ctrl                              mem,
    output logic                               rd_valid
);

    logic row_sel;

    // Top address bit picks the row
    assign row_sel = addr[scratch_ram_pkg::ADDR_W-1];

    // ------------------------------------------------------------
    // Row write enable decode
    // ------------------------------------------------------------
    always_comb
    begin
        for (int r = 0; r < scratch_ram_pkg::NUM_ROWS; r++)
        begin
            mem.row_wen[r] = wen && (int'(row_sel) == r);
        end
    end

    assign mem.tile_addr = addr[scratch_ram_pkg::ROW_ADDR_W-1:0];

    // Row select follows the tile read by one cycle
    always_ff @(posedge CLK)
    begin
        mem.row_sel_q <= row_sel;
    end

    // Any cycle without a write is a read
    always_ff @(posedge CLK)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= ~wen;
    end

endmodule

`default_nettype wire

// File: secded_encoder.sv
`default_nettype none

module secded_encoder #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] wd,
    input  logic                  inj_single,
    input  logic                  inj_double,
    array_if.enc                  mem
);

    localparam int CHECK_W = scratch_ram_pkg::ecc_check_width(DATA_WIDTH);
    localparam int HAM_W   = CHECK_W - 1;

    logic [HAM_W-1:0]      ham;
    logic                  parity;
    logic [DATA_WIDTH-1:0] flip;

    // ------------------------------------------------------------
    // Hamming bits: check bit b covers positions with bit b set
    // ------------------------------------------------------------
    always_comb
    begin
        ham = '0;
        for (int d = 0; d < DATA_WIDTH; d++)
        begin
            for (int b = 0; b < HAM_W; b++)
            begin
                if (((scratch_ram_pkg::ecc_data_pos(d) >> b) & 1) != 0)
                    ham[b] = ham[b] ^ wd[d];
            end
        end
    end

    // Overall parity over data and Hamming bits
    assign parity = ^{wd, ham};

    // ------------------------------------------------------------
    // Error injection, double wins over single
    // ------------------------------------------------------------
    always_comb
    begin
        flip = '0;
        if (inj_double)
            flip[1:0] = 2'b11;
        else if (inj_single)
            flip[0] = 1'b1;
    end

    // Check bits come from clean data, so the flip shows up on read
    assign mem.wr_data  = wd ^ flip;
    assign mem.wr_check = {parity, ham};

endmodule

`default_nettype wire

// File: secded_decoder.sv
`default_nettype none

module secded_decoder #(
    parameter int DATA_WIDTH = 32
) (
    array_if.dec                  mem,
    input  logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] rd,
    output logic                  sb_correct,
    output logic                  db_detect
);

    localparam int CHECK_W = scratch_ram_pkg::ecc_check_width(DATA_WIDTH);
    localparam int HAM_W   = CHECK_W - 1;

    logic [HAM_W-1:0]      syndrome;
    logic                  syn_nz;
    logic                  parity_err;
    logic [DATA_WIDTH-1:0] fixed;

    // ------------------------------------------------------------
    // Syndrome: stored Hamming bits against recomputed ones
    // ------------------------------------------------------------
    always_comb
    begin
        syndrome = mem.rd_check[HAM_W-1:0];
        for (int d = 0; d < DATA_WIDTH; d++)
        begin
            for (int b = 0; b < HAM_W; b++)
            begin
                if (((scratch_ram_pkg::ecc_data_pos(d) >> b) & 1) != 0)
                    syndrome[b] = syndrome[b] ^ mem.rd_data[d];
            end
        end
    end

    assign syn_nz = |syndrome;

    // Odd number of flipped bits anywhere in the codeword
    assign parity_err = ^{mem.rd_data, mem.rd_check};

    // ------------------------------------------------------------
    // Correction
    // ------------------------------------------------------------
    // Syndrome names the bad position; a check-bit position leaves data alone
    always_comb
    begin
        fixed = mem.rd_data;
        if (parity_err)
        begin
            for (int d = 0; d < DATA_WIDTH; d++)
            begin
                if (syndrome == HAM_W'(scratch_ram_pkg::ecc_data_pos(d)))
                    fixed[d] = ~mem.rd_data[d];
            end
        end
    end

    assign rd = fixed;

    // ------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------
    // Zero syndrome with bad parity is the parity bit itself
    assign sb_correct = rd_valid & parity_err;

    // Even error count with nonzero syndrome cannot be repaired
    assign db_detect  = rd_valid & syn_nz & ~parity_err;

endmodule

`default_nettype wire

// File: ecc_scratch_ram.sv
`default_nettype none

module ecc_scratch_ram #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                               CLK,
    input  logic                               rst,
    input  logic                               wen,
    input  logic [scratch_ram_pkg::ADDR_W-1:0] addr,
    input  logic [DATA_WIDTH-1:0]              wd,
    input  logic                               inj_single,
    input  logic                               inj_double,
    output logic [DATA_WIDTH-1:0]              rd,
    output logic                               rd_valid,
    output logic                               sb_correct,
    output logic                               db_detect
);

    // Shared bus between control, codec and tiles
    array_if #(
        .DATA_WIDTH (DATA_WIDTH)
    ) mem_if ();

    // ------------------------------------------------------------
    // Write enables, tile address and read pipeline control
    // ------------------------------------------------------------
    ram_bank_ctrl u_ctrl (
        .CLK      (CLK),
        .rst      (rst),
        .wen      (wen),
        .addr     (addr),
        .mem      (mem_if.ctrl),
        .rd_valid (rd_valid)
    );

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    secded_encoder #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_encoder (
        .wd         (wd),
        .inj_single (inj_single),
        .inj_double (inj_double),
        .mem        (mem_if.enc)
    );

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    ram_array #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_array (
        .CLK (CLK),
        .mem (mem_if.array)
    );

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    secded_decoder #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_decoder (
        .mem        (mem_if.dec),
        .rd_valid   (rd_valid),
        .rd         (rd),
        .sb_correct (sb_correct),
        .db_detect  (db_detect)
    );

endmodule

`default_nettype wire

// File: ecc_scratch_ram_sva.sv
`default_nettype none

module ecc_scratch_ram_sva (
    input logic CLK,
    input logic rst,
    input logic wen,
    input logic rd_valid,
    input logic sb_correct,
    input logic db_detect
);

    int assert_fails = 0;

    // ------------------------------------------------------------
    // Flag rules
    // ------------------------------------------------------------
    a_flags_exclusive : assert property (@(posedge CLK) disable iff (rst)
        !(sb_correct && db_detect))
    else
    begin
        assert_fails++;
        $error("sb_correct and db_detect are high together");
    end

    // No flags without a valid read
    a_flags_need_valid : assert property (@(posedge CLK) disable iff (rst)
        !rd_valid |-> (!sb_correct && !db_detect))
    else
    begin
        assert_fails++;
        $error("ECC flag high while rd_valid is low");
    end

    // ------------------------------------------------------------
    // Read-valid timing
    // ------------------------------------------------------------
    a_valid_after_reset : assert property (@(posedge CLK)
        $fell(rst) |-> !rd_valid)
    else
    begin
        assert_fails++;
        $error("rd_valid high in the cycle after reset");
    end

    a_valid_after_write : assert property (@(posedge CLK) disable iff (rst)
        wen |=> !rd_valid)
    else
    begin
        assert_fails++;
        $error("rd_valid high in the cycle after a write");
    end

endmodule

bind ecc_scratch_ram ecc_scratch_ram_sva u_sva (
    .CLK        (CLK),
    .rst        (rst),
    .wen        (wen),
    .rd_valid   (rd_valid),
    .sb_correct (sb_correct),
    .db_detect  (db_detect)
);

`default_nettype wire

// File: ecc_scratch_ram_tb.sv
`default_nettype none

module ecc_scratch_ram_tb;

    localparam int DATA_WIDTH = 32;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_OPS    = 2000;
    localparam int NUM_WORDS  = 1 << scratch_ram_pkg::ADDR_W;
    localparam int WATCHDOG   = NUM_OPS * CLK_PERIOD * 4;

    // Injection kind kept per address
    localparam logic [1:0] INJ_NONE   = 2'd0;
    localparam logic [1:0] INJ_SINGLE = 2'd1;
    localparam logic [1:0] INJ_DOUBLE = 2'd2;

    // One expected result per cycle
    typedef struct packed {
        logic                  valid;
        logic                  check_data;
        logic [DATA_WIDTH-1:0] data;
        logic                  sb;
        logic                  db;
    } expect_t;

    logic                               CLK = 1'b0;
    logic                               rst;
    logic                               wen;
    logic [scratch_ram_pkg::ADDR_W-1:0] addr;
    logic [DATA_WIDTH-1:0]              wd;
    logic                               inj_single;
    logic                               inj_double;
    logic [DATA_WIDTH-1:0]              rd;
    logic                               rd_valid;
    logic                               sb_correct;
    logic                               db_detect;

    // Reference model
    logic [DATA_WIDTH-1:0] model_data [NUM_WORDS];
    logic [1:0]            model_inj  [NUM_WORDS];
    expect_t               exp_q [$];
    logic [31:0]           rng    = 32'h142a_4749;
    int                    errors = 0;

    ecc_scratch_ram #(
        .DATA_WIDTH (DATA_WIDTH)
    ) DUT (
        .CLK        (CLK),
        .rst        (rst),
        .wen        (wen),
        .addr       (addr),
        .wd         (wd),
        .inj_single (inj_single),
        .inj_double (inj_double),
        .rd         (rd),
        .rd_valid   (rd_valid),
        .sb_correct (sb_correct),
        .db_detect  (db_detect)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                               input logic [DATA_WIDTH-1:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    // Outputs of the previous cycle's operation are stable at the falling edge
    task automatic check_result();
        expect_t e;
        if (exp_q.size() > 0)
        begin
            e = exp_q.pop_front();
            check_value("rd_valid", 32'(rd_valid), 32'(e.valid));
            check_value("sb_correct", 32'(sb_correct), 32'(e.sb));
            check_value("db_detect", 32'(db_detect), 32'(e.db));
            if (e.check_data)
                check_value("rd", rd, e.data);
        end
    endtask

    task automatic apply_op(input logic w, input logic [7:0] a, input logic [31:0] d,
                            input logic s, input logic dbl);
        expect_t e;
        @(negedge CLK);
        check_result();
        wen        = w;
        addr       = a;
        wd         = d;
        inj_single = s;
        inj_double = dbl;
        e = '0;
        if (w)
        begin
            model_data[a] = d;
            if (dbl)
                model_inj[a] = INJ_DOUBLE;
            else if (s)
                model_inj[a] = INJ_SINGLE;
            else
                model_inj[a] = INJ_NONE;
        end
        else
        begin
            e.valid      = 1'b1;
            e.sb         = (model_inj[a] == INJ_SINGLE);
            e.db         = (model_inj[a] == INJ_DOUBLE);
            e.check_data = (model_inj[a] != INJ_DOUBLE);
            e.data       = model_data[a];
        end
        exp_q.push_back(e);
    endtask

    task automatic write_word(input logic [7:0] a, input logic [31:0] d,
                              input logic s, input logic dbl);
        apply_op(1'b1, a, d, s, dbl);
    endtask

    task automatic read_word(input logic [7:0] a);
        apply_op(1'b0, a, '0, 1'b0, 1'b0);
    endtask

    // ------------------------------------------------------------
    // Test phases
    // ------------------------------------------------------------
    // Same low address in both rows with injection on row 0 only
    task automatic exercise_rows();
        logic [31:0] r;
        logic [31:0] d0;
        logic [31:0] d1;
        logic [7:0]  lo;
        logic [7:0]  hi;
        r  = next_rand();
        d0 = next_rand();
        d1 = next_rand();
        lo = {1'b0, r[6:0]};
        hi = {1'b1, r[6:0]};
        write_word(lo, d0, 1'b0, 1'b0);
        write_word(hi, d1, 1'b0, 1'b0);
        read_word(lo);
        read_word(hi);
        write_word(lo, d0, 1'b1, 1'b0);
        read_word(lo);
        read_word(hi);
        write_word(lo, d0, 1'b0, 1'b1);
        read_word(lo);
        read_word(hi);
        // Clean rewrite clears the flags
        write_word(lo, d0, 1'b0, 1'b0);
        read_word(lo);
    endtask

    task automatic run_random(input int count);
        logic [31:0] r;
        logic [31:0] d;
        for (int i = 0; i < count; i++)
        begin
            r = next_rand();
            d = next_rand();
            if (r[3:0] < 4'd5)
                write_word(r[15:8], d, (r[18:16] == 3'd5) || (r[18:16] == 3'd7),
                           r[18:16] >= 3'd6);
            else
                read_word(r[15:8]);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        rst        = 1'b1;
        // Reads are requested during reset and only the reset keeps rd_valid low
        wen        = 1'b0;
        addr       = '0;
        wd         = '0;
        inj_single = 1'b0;
        inj_double = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        check_value("rd_valid", 32'(rd_valid), 32'd0);
        check_value("sb_correct", 32'(sb_correct), 32'd0);
        check_value("db_detect", 32'(db_detect), 32'd0);
        // First cycle out of reset writes word 0 so no read sees an unwritten word
        wen           = 1'b1;
        model_data[0] = '0;
        model_inj[0]  = INJ_NONE;
        exp_q.push_back('0);
        // Every word gets clean contents first
        for (int a = 0; a < NUM_WORDS; a++)
            write_word(8'(a), next_rand(), 1'b0, 1'b0);
        exercise_rows();
        run_random(NUM_OPS);
        @(negedge CLK);
        check_result();
        $display("Done: %0d check errors, %0d assertion failures", errors,
                 DUT.u_sva.assert_fails);
        if (errors == 0 && DUT.u_sva.assert_fails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG);
        $display("Timeout: run still going after %0d time units", WATCHDOG);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: ecc_scratch_ram.f
scratch_ram_pkg.sv
array_if.sv
ram_tile.sv
ram_array.sv
ram_bank_ctrl.sv
secded_encoder.sv
secded_decoder.sv
ecc_scratch_ram.sv
ecc_scratch_ram_sva.sv
ecc_scratch_ram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ECC scratchpad RAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ecc_scratch_ram_tb \
    -f ecc_scratch_ram.f -o ecc_scratch_ram_sim

./obj_dir/ecc_scratch_ram_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
